//--- verilog/mdec_config.svh
`ifndef MDEC_CONFIG_SVH
`define MDEC_CONFIG_SVH

// --------------------------------------------------
// FIFO sizing
// --------------------------------------------------
`define MDEC_FIFO_DEPTH_W	5	// 32 entries per FIFO

// Host data path width
`define MDEC_WORD_W			32

// --------------------------------------------------
// Table sizes in words
// --------------------------------------------------
`define MDEC_QUANT_WORDS	16	// 64 bytes per quant table
`define MDEC_COS_WORDS		32	// Counted and dropped

`endif

//--- verilog/mdecPkg.sv
package mdecPkg;

	// --------------------------------------------------
	// Command field, bits 31..29 of a command word
	// --------------------------------------------------
	typedef enum logic [2:0] {
		STREAM_CMD	= 3'd1,	// Low half is word count
		QUANTI_CMD	= 3'd2,	// Bit 0 adds chroma table
		COSTBL_CMD	= 3'd3	// 32 words, discarded
	} mdecCmd;

	// Sequencer states
	typedef enum logic [2:0] {
		WAIT_COMMAND	= 3'd0,
		LOAD_STREAML	= 3'd1,	// First halfword of a stream word
		LOAD_STREAMH	= 3'd2,	// Second halfword, word popped here
		LOAD_COS		= 3'd3,
		LOAD_LUMA		= 3'd4,
		LOAD_CHROMA		= 3'd5
	} cmdState;

	// Output setup, taken from command bits 28..25
	typedef struct packed {
		logic [1:0]	format;		// Pixel depth code
		logic		isSigned;
		logic		setMask;	// Bit 15 set for 15-bit output
	} pixelSetup;

	// One quant table word toward the dequantizer
	typedef struct packed {
		logic			write;
		logic			chroma;	// 1 selects chroma table
		logic [3:0]		addr;	// Word index inside the table
		logic [3:0][7:0]	data;	// Byte 0 at the lowest table index
	} quantWrite;

	// One stream halfword toward the dequantizer
	typedef struct packed {
		logic			write;
		logic [15:0]	half;	// Run 15..10, level 9..0
	} streamHalf;

	// Output FIFO word
	typedef struct packed {
		logic [2:0]			block;
		logic [5:0]			position;
		logic signed [22:0]	product;
	} coefWord;

endpackage

//--- verilog/wordFifo.sv
`timescale 1ns/1ps
`include "mdec_config.svh"

module wordFifo (
	input  logic						i_clk,
	input  logic						i_resetChip,
	input  logic						i_push,
	input  logic [`MDEC_WORD_W-1:0]		i_data,
	input  logic						i_pop,
	output logic [`MDEC_WORD_W-1:0]		o_data,
	output logic						o_empty,
	output logic						o_full
);
	localparam int DEPTH = 1 << `MDEC_FIFO_DEPTH_W;

	logic [`MDEC_WORD_W-1:0]		mem [DEPTH];
	logic [`MDEC_FIFO_DEPTH_W-1:0]	wrPtr;
	logic [`MDEC_FIFO_DEPTH_W-1:0]	rdPtr;
	logic [`MDEC_FIFO_DEPTH_W:0]	level;		// One extra bit so full is distinct
	logic							doPush;
	logic							doPop;

	assign doPush	= i_push && !o_full;		// Dropped when full
	assign doPop	= i_pop && !o_empty;		// Ignored when empty
	assign o_empty	= (level == '0);
	assign o_full	= level[`MDEC_FIFO_DEPTH_W];	// Only set at exactly DEPTH

	// Head word falls through, no read latency
	assign o_data	= mem[rdPtr];

	// --------------------------------------------------
	// Storage
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (doPush) begin
			mem[wrPtr] <= i_data;
		end
	end

	// Pointers and fill level
	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			wrPtr	<= '0;
			rdPtr	<= '0;
			level	<= '0;
		end else begin
			if (doPush) begin
				wrPtr <= wrPtr + 1'b1;		// Wraps at depth
			end
			if (doPop) begin
				rdPtr <= rdPtr + 1'b1;
			end
			case ({doPush, doPop})
				2'b10:		level <= level + 1'b1;
				2'b01:		level <= level - 1'b1;
				default:	level <= level;	// Both or neither
			endcase
		end
	end

endmodule

//--- verilog/hostPort.sv
`timescale 1ns/1ps
`include "mdec_config.svh"

module hostPort
	import mdecPkg::*;
(
	input  logic					i_clk,
	input  logic					i_resetChip,
	input  logic					i_regSelect,	// 0 data port, 1 control/status
	input  logic					i_write,
	input  logic					i_read,
	input  logic [`MDEC_WORD_W-1:0]	i_valueIn,
	input  logic [`MDEC_WORD_W-1:0]	i_outHead,
	input  logic					i_outEmpty,
	input  logic					i_inFull,
	input  logic					i_busy,
	input  pixelSetup				i_setup,
	input  logic [2:0]				i_block,
	input  logic [15:0]				i_remaining,
	output logic					o_resetChip,
	output logic					o_pushIn,
	output logic					o_popOut,
	output logic [`MDEC_WORD_W-1:0]	o_valueOut,
	output logic					o_canWriteReg0,
	output logic					o_dma0Request,
	output logic					o_dma1Request
);
	logic						writeReg0;
	logic						writeReg1;
	logic						resetChip;
	logic						dma0Enable;
	logic						dma1Enable;
	logic [`MDEC_WORD_W-1:0]	statusWord;
	logic [`MDEC_WORD_W-1:0]	dataWord;

	assign writeReg0	= !i_regSelect && i_write;
	assign writeReg1	= i_regSelect && i_write;

	// Soft reset on reg 1 bit 31, lasts only the write cycle
	assign resetChip	= i_resetChip || (writeReg1 && i_valueIn[31]);
	assign o_resetChip	= resetChip;

	assign o_pushIn		= writeReg0;				// FIFO drops it when full
	assign o_popOut		= !i_regSelect && i_read && !i_outEmpty;

	// --------------------------------------------------
	// DMA request enables
	// --------------------------------------------------
	// Bits 30 and 29 of a reg 1 write are disable bits, a 0 re-enables
	always_ff @(posedge i_clk) begin
		if (resetChip) begin
			dma0Enable	<= 1'b1;
			dma1Enable	<= 1'b1;
		end else if (writeReg1) begin
			dma0Enable	<= !i_valueIn[30];
			dma1Enable	<= !i_valueIn[29];
		end
	end

	// --------------------------------------------------
	// Status word, 0x9000FFFF straight out of reset
	// --------------------------------------------------
	assign statusWord[31]		= i_outEmpty;
	assign statusWord[30]		= i_inFull;
	assign statusWord[29]		= i_busy;
	assign statusWord[28]		= !i_inFull && dma0Enable;	// Data-in request
	assign statusWord[27]		= !i_outEmpty && dma1Enable;	// Data-out request
	assign statusWord[26:23]	= i_setup;				// Format, signed, mask
	assign statusWord[22:19]	= 4'b0000;
	assign statusWord[18:16]	= i_block;
	assign statusWord[15:0]		= i_remaining;			// Words left minus one

	// Empty output FIFO reads back as zero
	assign dataWord			= i_outEmpty ? '0 : i_outHead;

	assign o_valueOut		= i_regSelect ? statusWord : dataWord;
	assign o_canWriteReg0	= !i_inFull;
	assign o_dma0Request	= statusWord[28];
	assign o_dma1Request	= statusWord[27];

endmodule

//--- verilog/commandSequencer.sv
`timescale 1ns/1ps
`include "mdec_config.svh"

module commandSequencer
	import mdecPkg::*;
(
	input  logic					i_clk,
	input  logic					i_resetChip,
	input  logic [`MDEC_WORD_W-1:0]	i_inHead,		// Input FIFO head word
	input  logic					i_inEmpty,
	input  logic					i_hold,			// Output side full
	output logic					o_popIn,
	output logic					o_busy,
	output pixelSetup				o_setup,
	output logic [15:0]				o_remaining,
	output quantWrite				o_quant,
	output streamHalf				o_stream
);
	cmdState		state;
	cmdState		nextState;
	mdecCmd			command;
	pixelSetup		setupReg;
	logic [16:0]	remHalf;		// Halfwords left in the current command
	logic [3:0]		tableAddr;
	logic			loadChroma;
	logic			inValid;
	logic			streamGo;
	logic			lastTableWord;
	logic			lastCosWord;
	logic			lastHalf;
	logic			popIn;
	logic			decHalf;		// Stream halfword consumed
	logic			decWord;		// Table word consumed
	logic			quantStrobe;
	logic			streamStrobe;

	assign command			= mdecCmd'(i_inHead[31:29]);
	assign inValid			= !i_inEmpty;
	assign streamGo			= inValid && !i_hold;	// Stall on full output
	assign lastTableWord	= (tableAddr == 4'(`MDEC_QUANT_WORDS - 1));
	assign lastCosWord		= (remHalf == 17'd2);
	assign lastHalf			= (remHalf == 17'd1);

	// --------------------------------------------------
	// Next state and strobes
	// --------------------------------------------------
	always_comb begin
		nextState		= state;
		popIn			= 1'b0;
		decHalf			= 1'b0;
		decWord			= 1'b0;
		quantStrobe		= 1'b0;
		streamStrobe	= 1'b0;
		case (state)
			WAIT_COMMAND: begin
				if (inValid) begin
					popIn = 1'b1;			// Unknown commands just dropped
					case (command)
						STREAM_CMD:	nextState = (i_inHead[15:0] != 16'd0) ? LOAD_STREAML
														: WAIT_COMMAND;
						QUANTI_CMD:	nextState = LOAD_LUMA;
						COSTBL_CMD:	nextState = LOAD_COS;
						default:	nextState = WAIT_COMMAND;
					endcase
				end
			end
			LOAD_STREAML: begin
				if (streamGo) begin
					streamStrobe	= 1'b1;	// Low half, word stays in FIFO
					decHalf			= 1'b1;
					nextState		= LOAD_STREAMH;
				end
			end
			LOAD_STREAMH: begin
				if (streamGo) begin
					streamStrobe	= 1'b1;
					popIn			= 1'b1;	// Both halves used
					decHalf			= 1'b1;
					nextState		= lastHalf ? WAIT_COMMAND : LOAD_STREAML;
				end
			end
			LOAD_COS: begin
				if (inValid) begin
					popIn		= 1'b1;
					decWord		= 1'b1;
					nextState	= lastCosWord ? WAIT_COMMAND : LOAD_COS;
				end
			end
			LOAD_LUMA, LOAD_CHROMA: begin
				if (inValid) begin
					popIn		= 1'b1;
					decWord		= 1'b1;
					quantStrobe	= 1'b1;
					if (lastTableWord) begin
						// Chroma only follows luma when asked for
						nextState = (state == LOAD_LUMA && loadChroma) ? LOAD_CHROMA
													: WAIT_COMMAND;
					end
				end
			end
			default: nextState = WAIT_COMMAND;
		endcase
	end

	// --------------------------------------------------
	// State, counters and command setup
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			state		<= WAIT_COMMAND;
			remHalf		<= '0;
			tableAddr	<= '0;
			loadChroma	<= 1'b0;
			setupReg	<= '0;
		end else begin
			state <= nextState;
			if (state == WAIT_COMMAND && inValid) begin
				setupReg	<= i_inHead[28:25];	// Stored for any command
				loadChroma	<= i_inHead[0];
				tableAddr	<= '0;
				case (command)
					STREAM_CMD:	remHalf <= {i_inHead[15:0], 1'b0};
					QUANTI_CMD:	remHalf <= i_inHead[0] ? 17'(`MDEC_QUANT_WORDS * 4)
														: 17'(`MDEC_QUANT_WORDS * 2);
					COSTBL_CMD:	remHalf <= 17'(`MDEC_COS_WORDS * 2);
					default:	remHalf <= '0;
				endcase
			end else begin
				if (decHalf) begin
					remHalf <= remHalf - 17'd1;
				end else if (decWord) begin
					remHalf <= remHalf - 17'd2;
				end
				if (quantStrobe) begin
					tableAddr <= tableAddr + 4'd1;	// Wraps to 0 for chroma
				end
			end
		end
	end

	assign o_popIn		= popIn;
	assign o_busy		= (state != WAIT_COMMAND) || inValid;
	assign o_setup		= setupReg;
	assign o_remaining	= remHalf[16:1] - 16'd1;	// 0xFFFF when nothing left

	assign o_quant.write	= quantStrobe;
	assign o_quant.chroma	= (state == LOAD_CHROMA);
	assign o_quant.addr		= tableAddr;
	assign o_quant.data		= i_inHead;

	assign o_stream.write	= streamStrobe;
	assign o_stream.half	= (state == LOAD_STREAML) ? i_inHead[15:0] : i_inHead[31:16];

endmodule

//--- verilog/coefDequantizer.sv
`timescale 1ns/1ps
`include "mdec_config.svh"

module coefDequantizer
	import mdecPkg::*;
(
	input  logic		i_clk,
	input  logic		i_resetChip,
	input  quantWrite	i_quant,
	input  streamHalf	i_stream,
	input  logic		i_outFull,
	output logic		o_push,
	output coefWord		o_coef,
	output logic [2:0]	o_block,
	output logic		o_hold
);
	localparam int TABLE_BYTES = `MDEC_QUANT_WORDS * 4;

	logic [7:0]			lumaTable [TABLE_BYTES];
	logic [7:0]			chromaTable [TABLE_BYTES];
	logic [5:0]			position;		// Next coefficient index in block
	logic [2:0]			block;
	logic				pushValid;
	coefWord			coefReg;
	logic				accept;
	logic				endOfBlock;
	logic [5:0]			run;
	logic signed [9:0]	level;
	logic [5:0]			coefPos;
	logic [7:0]			scale;
	logic signed [18:0]	rawProduct;

	// Sequencer only strobes while the output FIFO has room
	assign accept		= i_stream.write;
	assign endOfBlock	= (i_stream.half == 16'hFE00);
	assign run			= i_stream.half[15:10];
	assign level		= i_stream.half[9:0];

	// --------------------------------------------------
	// Quant tables written four bytes at a time
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_quant.write) begin
			for (int i = 0; i < 4; i++) begin
				if (i_quant.chroma) begin
					chromaTable[{i_quant.addr, 2'(i)}] <= i_quant.data[i];
				end else begin
					lumaTable[{i_quant.addr, 2'(i)}] <= i_quant.data[i];
				end
			end
		end
	end

	// Skip the zero run modulo 64
	assign coefPos		= position + run;
	assign scale		= (block < 3'd2) ? chromaTable[coefPos] : lumaTable[coefPos];
	assign rawProduct	= level * $signed({1'b0, scale});	// Table byte is unsigned

	// --------------------------------------------------
	// Run-length tracking and block count
	// --------------------------------------------------
	always_ff @(posedge i_clk) begin
		if (i_resetChip) begin
			position	<= '0;
			block		<= '0;
			pushValid	<= 1'b0;
		end else if (accept) begin
			if (endOfBlock) begin
				position	<= '0;
				block		<= (block == 3'd5) ? 3'd0 : block + 3'd1;	// Six blocks
				pushValid	<= 1'b0;	// Pending push lands this edge
			end else begin
				position	<= coefPos + 6'd1;
				pushValid	<= 1'b1;
			end
		end else if (!i_outFull) begin
			pushValid <= 1'b0;			// Pushed, or nothing pending
		end
	end

	// Product register holds while the FIFO is full
	always_ff @(posedge i_clk) begin
		if (accept && !endOfBlock) begin
			coefReg.block		<= block;
			coefReg.position	<= coefPos;
			coefReg.product		<= {{4{rawProduct[18]}}, rawProduct};
		end
	end

	assign o_push	= pushValid;
	assign o_coef	= coefReg;
	assign o_block	= block;
	assign o_hold	= i_outFull;

endmodule

//--- verilog/mdecTop.sv
`timescale 1ns/1ps
`include "mdec_config.svh"

module mdecTop
	import mdecPkg::*;
(
	input  logic					i_clk,
	input  logic					i_resetChip,
	input  logic					i_regSelect,
	input  logic					i_write,
	input  logic					i_read,
	input  logic [`MDEC_WORD_W-1:0]	i_valueIn,
	output logic [`MDEC_WORD_W-1:0]	o_valueOut,
	output logic					o_canWriteReg0,
	output logic					o_dma0Request,
	output logic					o_dma1Request
);
	logic						resetChip;		// External or soft reset
	logic						pushIn;
	logic						popIn;
	logic [`MDEC_WORD_W-1:0]	inHead;
	logic						inEmpty;
	logic						inFull;
	logic						popOut;
	logic						coefPush;
	logic [`MDEC_WORD_W-1:0]	outHead;
	logic						outEmpty;
	logic						outFull;
	logic						busy;
	logic						hold;
	logic [2:0]					block;
	logic [15:0]				remaining;
	pixelSetup					setup;
	quantWrite					quant;
	streamHalf					stream;
	coefWord					coef;

	// --------------------------------------------------
	// Register front end
	// --------------------------------------------------
	hostPort hostPort0 (
		.i_clk(i_clk), .i_resetChip(i_resetChip), .i_regSelect(i_regSelect),
		.i_write(i_write), .i_read(i_read), .i_valueIn(i_valueIn),
		.i_outHead(outHead), .i_outEmpty(outEmpty), .i_inFull(inFull),
		.i_busy(busy), .i_setup(setup), .i_block(block), .i_remaining(remaining),
		.o_resetChip(resetChip), .o_pushIn(pushIn), .o_popOut(popOut),
		.o_valueOut(o_valueOut), .o_canWriteReg0(o_canWriteReg0),
		.o_dma0Request(o_dma0Request), .o_dma1Request(o_dma1Request)
	);

	// Command and data words from the host
	wordFifo inFifo (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_push(pushIn), .i_data(i_valueIn),
		.i_pop(popIn), .o_data(inHead), .o_empty(inEmpty), .o_full(inFull)
	);

	// --------------------------------------------------
	// Processing
	// --------------------------------------------------
	commandSequencer seq0 (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_inHead(inHead),
		.i_inEmpty(inEmpty), .i_hold(hold), .o_popIn(popIn), .o_busy(busy),
		.o_setup(setup), .o_remaining(remaining), .o_quant(quant), .o_stream(stream)
	);

	coefDequantizer deq0 (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_quant(quant), .i_stream(stream),
		.i_outFull(outFull), .o_push(coefPush), .o_coef(coef), .o_block(block),
		.o_hold(hold)
	);

	// Coefficient words back to the host
	wordFifo outFifo (
		.i_clk(i_clk), .i_resetChip(resetChip), .i_push(coefPush), .i_data(coef),
		.i_pop(popOut), .o_data(outHead), .o_empty(outEmpty), .o_full(outFull)
	);

endmodule

//--- sim/mdecTb.sv
`timescale 1ns/1ps

module mdecTb;

	// Table operations
	typedef enum logic [1:0] {
		OP_WRITE	= 2'd0,
		OP_READ		= 2'd1,	// Read and compare
		OP_IDLE		= 2'd2,	// Poll status until busy clears
		OP_PINS		= 2'd3	// Compare canWrite, dma0, dma1
	} tbOp;

	typedef struct packed {
		tbOp			op;
		logic			regSel;
		logic [31:0]	data;
		logic [31:0]	expected;
	} tableEntry;

	localparam logic [2:0]	STREAM_CODE		= 3'd1;
	localparam logic [2:0]	QUANT_CODE		= 3'd2;
	localparam logic [2:0]	COSTBL_CODE		= 3'd3;
	localparam logic [15:0]	END_OF_BLOCK	= 16'hFE00;

	logic			clk;
	logic			resetChip;
	logic			regSelect;
	logic			write;
	logic			read;
	logic [31:0]	valueIn;
	logic [31:0]	valueOut;
	logic			canWrite;
	logic			dma0Req;
	logic			dma1Req;

	tableEntry		stimTable[$];
	logic [31:0]	expectOut[$];		// Model coefficient words in order
	logic [15:0]	halves[$];			// Stream halfwords of the next command
	logic [7:0]		lumaModel[64];
	logic [7:0]		chromaModel[64];
	int				modelPos;
	int				modelBlock;
	logic [15:0]	lfsrState;
	int				errors = 0;
	int				checks = 0;
	int				cycles = 0;
	int				cycleLimit = 0;

	mdecTop dut0 (
		.i_clk(clk), .i_resetChip(resetChip), .i_regSelect(regSelect),
		.i_write(write), .i_read(read), .i_valueIn(valueIn), .o_valueOut(valueOut),
		.o_canWriteReg0(canWrite), .o_dma0Request(dma0Req), .o_dma1Request(dma1Req)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;		// 4 ns period
	end

	// Run limit from table length
	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycleLimit > 0 && cycles > cycleLimit) begin
			$display("Timeout: the table did not finish within %0d cycles", cycleLimit);
			$display("Test failures found");
			$finish;
		end
	end

	// --------------------------------------------------
	// Random bits, 16-bit Fibonacci LFSR
	// --------------------------------------------------
	function logic lfsrBit();
		logic fb;
		fb = lfsrState[15] ^ lfsrState[13] ^ lfsrState[12] ^ lfsrState[10];
		lfsrState = {lfsrState[14:0], fb};
		return fb;
	endfunction

	function logic [15:0] randomBits(input int width);
		logic [15:0] value;
		value = '0;
		for (int i = 0; i < width; i++) begin
			value = {value[14:0], lfsrBit()};	// One step per bit
		end
		return value;
	endfunction

	// Status layout from the register map
	function logic [31:0] statusWord(input logic outEmpty, input logic inFull,
			input logic busy, input logic dma0En, input logic dma1En,
			input logic [3:0] setup, input int blk, input logic [15:0] remaining);
		logic [31:0] s;
		s = '0;
		s[31]		= outEmpty;
		s[30]		= inFull;
		s[29]		= busy;
		s[28]		= !inFull && dma0En;
		s[27]		= !outEmpty && dma1En;
		s[26:23]	= setup;
		s[18:16]	= 3'(blk);
		s[15:0]		= remaining;
		return s;
	endfunction

	function logic [31:0] tableWord(input logic chroma, input int k);
		logic [31:0] word;
		for (int b = 0; b < 4; b++) begin
			word[8*b +: 8] = chroma ? chromaModel[4*k+b] : lumaModel[4*k+b];	// Low byte first
		end
		return word;
	endfunction

	// --------------------------------------------------
	// Table building
	// --------------------------------------------------
	task addEntry(input tbOp op, input logic regSel, input logic [31:0] data,
			input logic [31:0] expected);
		tableEntry e;
		e.op		= op;
		e.regSel	= regSel;
		e.data		= data;
		e.expected	= expected;
		stimTable.push_back(e);
	endtask

	task addWrite(input logic regSel, input logic [31:0] data);
		addEntry(OP_WRITE, regSel, data, '0);
	endtask

	task addRead(input logic regSel, input logic [31:0] expected);
		addEntry(OP_READ, regSel, '0, expected);
	endtask

	task addPins(input logic [2:0] bits);
		addEntry(OP_PINS, 1'b1, '0, {29'd0, bits});	// {canWrite, dma0, dma1}
	endtask

	// Dequantizer rule for one halfword
	task modelHalf(input logic [15:0] h);
		int run;
		int level;
		int pos;
		int scale;
		int product;
		if (h == END_OF_BLOCK) begin
			modelPos	= 0;
			modelBlock	= (modelBlock == 5) ? 0 : modelBlock + 1;
		end else begin
			run		= h[15:10];
			level	= h[9] ? int'(h[9:0]) - 1024 : int'(h[9:0]);	// Signed 10-bit
			pos		= (modelPos + run) % 64;
			scale	= (modelBlock < 2) ? chromaModel[pos] : lumaModel[pos];
			product	= level * scale;
			expectOut.push_back({3'(modelBlock), 6'(pos), 23'(product)});
			modelPos = (pos + 1) % 64;
		end
	endtask

	task makeCoefs(input int count, input bit endBlock);
		logic [15:0] runBits;
		logic [15:0] levelBits;
		for (int i = 0; i < count; i++) begin
			runBits		= randomBits(3);	// Short runs keep positions spread
			levelBits	= randomBits(10);
			halves.push_back({3'b000, runBits[2:0], levelBits[9:0]});
		end
		if (endBlock) begin
			halves.push_back(END_OF_BLOCK);
		end
	endtask

	// Stream command plus words, low halfword first
	task sendStream(input logic [3:0] setup);
		int words;
		words = halves.size() / 2;
		addWrite(1'b0, {STREAM_CODE, setup, 9'd0, 16'(words)});
		for (int i = 0; i < words; i++) begin
			addWrite(1'b0, {halves[2*i+1], halves[2*i]});
		end
		foreach (halves[i]) begin
			modelHalf(halves[i]);
		end
		halves.delete();
	endtask

	task drainOutputs();
		while (expectOut.size() > 0) begin
			addRead(1'b0, expectOut.pop_front());
		end
	endtask

	task buildTable();
		for (int i = 0; i < 64; i++) begin
			lumaModel[i]	= 8'(i * 37 + 11);
			chromaModel[i]	= 8'(i * 19 + 200);
		end
		modelPos	= 0;
		modelBlock	= 0;

		// Reset values
		addRead(1'b1, 32'h9000FFFF);
		addPins(3'b110);

		// Quant load, luma then chroma
		addWrite(1'b0, {QUANT_CODE, 4'b1011, 24'd0, 1'b1});
		for (int k = 0; k < 16; k++) addWrite(1'b0, tableWord(1'b0, k));
		for (int k = 0; k < 16; k++) addWrite(1'b0, tableWord(1'b1, k));
		addEntry(OP_IDLE, 1'b1, '0, '0);
		addRead(1'b1, statusWord(1, 0, 0, 1, 1, 4'b1011, 0, 16'hFFFF));

		// --------------------------------------------------
		// Stream of three blocks
		// --------------------------------------------------
		makeCoefs(5, 1);
		makeCoefs(5, 1);
		makeCoefs(3, 1);
		sendStream(4'b0110);
		addEntry(OP_IDLE, 1'b1, '0, '0);
		addRead(1'b1, statusWord(0, 0, 0, 1, 1, 4'b0110, modelBlock, 16'hFFFF));
		drainOutputs();
		addRead(1'b1, statusWord(1, 0, 0, 1, 1, 4'b0110, modelBlock, 16'hFFFF));

		// Cos table, two reads mid-load see 9 then 10 words taken
		addWrite(1'b0, {COSTBL_CODE, 29'd0});
		for (int k = 1; k <= 10; k++) addWrite(1'b0, 32'(k * 32'h01010101));
		addRead(1'b1, statusWord(1, 0, 1, 1, 1, 4'b0000, modelBlock, 16'd22));
		addRead(1'b1, statusWord(1, 0, 1, 1, 1, 4'b0000, modelBlock, 16'd21));
		for (int k = 11; k <= 32; k++) addWrite(1'b0, 32'(k * 32'h01010101));
		addEntry(OP_IDLE, 1'b1, '0, '0);
		addRead(1'b1, statusWord(1, 0, 0, 1, 1, 4'b0000, modelBlock, 16'hFFFF));

		// --------------------------------------------------
		// DMA enables off, then soft reset
		// --------------------------------------------------
		addWrite(1'b1, 32'h60000000);
		addPins(3'b100);
		makeCoefs(1, 1);
		sendStream(4'b0001);
		addEntry(OP_IDLE, 1'b1, '0, '0);
		addPins(3'b100);					// Output present, no request
		addRead(1'b1, statusWord(0, 0, 0, 0, 0, 4'b0001, modelBlock, 16'hFFFF));
		addWrite(1'b1, 32'h80000000);
		expectOut.delete();					// Output FIFO flushed
		modelPos	= 0;
		modelBlock	= 0;
		addRead(1'b1, 32'h9000FFFF);
		addPins(3'b110);

		// Fill the output FIFO exactly, then stall a second stream
		makeCoefs(32, 0);
		sendStream(4'b1100);
		addEntry(OP_IDLE, 1'b1, '0, '0);
		addRead(1'b1, statusWord(0, 0, 0, 1, 1, 4'b1100, 0, 16'hFFFF));
		makeCoefs(64, 0);
		sendStream(4'b0011);				// 32 words queue up behind the stall
		addPins(3'b001);
		addRead(1'b1, statusWord(0, 1, 1, 0, 1, 4'b0011, modelBlock, 16'd31));
		drainOutputs();
		addEntry(OP_IDLE, 1'b1, '0, '0);
		addRead(1'b1, statusWord(1, 0, 0, 1, 1, 4'b0011, modelBlock, 16'hFFFF));
	endtask

	// --------------------------------------------------
	// Checks and table application
	// --------------------------------------------------
	task checkValue(input string name, input logic [31:0] got, input logic [31:0] expected);
		checks++;
		assert (got === expected) else begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, expected);
		end
	endtask

	task applyEntry(input tableEntry e);
		@(negedge clk);
		regSelect	= e.regSel;
		write		= 1'b0;
		read		= 1'b0;
		valueIn		= '0;
		case (e.op)
			OP_WRITE: begin
				write	= 1'b1;
				valueIn	= e.data;
			end
			OP_READ: begin
				read = 1'b1;
				#1;							// Mid low phase, settled
				if (e.regSel) begin
					checkValue("o_valueOut status", valueOut, e.expected);
				end else begin
					checkValue("o_valueOut data", valueOut, e.expected);
				end
			end
			OP_IDLE: begin
				read = 1'b1;
				#1;
				while (valueOut[29]) begin	// Busy bit
					@(negedge clk);
					#1;
				end
			end
			default: begin
				#1;
				checkValue("o_canWriteReg0", {31'd0, canWrite}, {31'd0, e.expected[2]});
				checkValue("o_dma0Request", {31'd0, dma0Req}, {31'd0, e.expected[1]});
				checkValue("o_dma1Request", {31'd0, dma1Req}, {31'd0, e.expected[0]});
			end
		endcase
	endtask

	initial begin
		resetChip	= 1'b1;
		regSelect	= 1'b0;
		write		= 1'b0;
		read		= 1'b0;
		valueIn		= '0;
		lfsrState	= 16'd57;
		buildTable();
		cycleLimit	= stimTable.size() * 40;
		repeat (16) @(posedge clk);
		@(negedge clk);
		resetChip = 1'b0;
		foreach (stimTable[i]) begin
			applyEntry(stimTable[i]);
		end
		@(negedge clk);
		write	= 1'b0;
		read	= 1'b0;
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- list.f
+incdir+verilog
verilog/mdecPkg.sv
verilog/wordFifo.sv
verilog/hostPort.sv
verilog/commandSequencer.sv
verilog/coefDequantizer.sv
verilog/mdecTop.sv
sim/mdecTb.sv

//--- Makefile
# Verilator build and run for the MDEC front end

VERILATOR ?= verilator
TOP       ?= mdecTb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_TEXT ?= All tests passed!

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS PASS_TEXT"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qxF "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)
